// File: project.f
logic/mac_rx_pkg.sv
logic/mac_rx_ctrl.sv
logic/rx_crc32.sv
logic/rx_word_packer.sv
logic/rx_frame_status.sv
logic/mac_rx.sv
dv/mac_rx_checker.sv
dv/tb_mac_rx.sv

// File: Bender.yml
package:
  name: mac_rx

sources:
  - logic/mac_rx_pkg.sv
  - logic/mac_rx_ctrl.sv
  - logic/rx_crc32.sv
  - logic/rx_word_packer.sv
  - logic/rx_frame_status.sv
  - logic/mac_rx.sv
  - target: simulation
    files:
      - dv/mac_rx_checker.sv
      - dv/tb_mac_rx.sv

// File: dv/tb_mac_rx.sv
// ------------------------------
// clock, reset, random frames,
// drive, watchdog and report
// ------------------------------
`timescale 1ns/10ps

module tb_mac_rx;
    localparam int min_len    = 64;
    localparam int max_len    = 1522;
    localparam int num_frames = 14;

    typedef enum int {kind_good, kind_bad_fcs, kind_runt, kind_oversize, kind_broken} kind_t;

    logic                   sys_clk = 1'b0;
    logic                   rst_n;
    mac_rx_pkg::byte_t      phy_data;
    logic                   data_valid;
    logic                   word_stb;
    mac_rx_pkg::rx_word_t   word_out;
    logic                   frame_done;
    mac_rx_pkg::rx_status_t status;

    logic [31:0] lcg_state = 32'd52298;
    kind_t       kinds[num_frames];
    int          pre_lens[num_frames];
    int          lens[num_frames];   // bytes after the SFD including the FCS
    int          gaps[num_frames];
    bit          corrupt[num_frames];
    int          budget_cycles = 0;
    bit          budget_ready = 1'b0;
    int          tb_errs = 0;
    int          valid_frames = 0;

    always #50 sys_clk = ~sys_clk;

    mac_rx #(
        .min_frame_size (min_len),
        .max_frame_size (max_len)
    ) u_dut (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .phy_data   (phy_data),
        .data_valid (data_valid),
        .word_stb   (word_stb),
        .word_out   (word_out),
        .frame_done (frame_done),
        .status     (status)
    );

    mac_rx_checker u_checker (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .word_stb   (word_stb),
        .word_out   (word_out),
        .frame_done (frame_done),
        .status     (status)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {8'h00, lcg_state[31:8]};  // low bits cycle too fast
    endfunction

    // serial reflected CRC-32 taking each byte lsb first
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        int          k;
        c = crc;
        for (k = 0; k < 8; k++)
            c = (c[0] ^ b[k]) ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        return c;
    endfunction

    function automatic kind_t kind_of(input int idx);
        case (idx)
            0, 5, 9, 12: return kind_good;
            1, 10:       return kind_bad_fcs;
            3:           return kind_oversize;
            4:           return kind_broken;
            default:     return kind_runt;
        endcase
    endfunction

    task automatic plan_frames();
        int i;
        for (i = 0; i < num_frames; i++) begin
            kinds[i]    = kind_of(i);
            pre_lens[i] = 1 + lcg_next() % 7;
            case (kinds[i])
                kind_runt:     lens[i] = 8 + lcg_next() % 56;
                kind_oversize: lens[i] = max_len + 1 + lcg_next() % 78;
                default:       lens[i] = min_len + lcg_next() % (max_len - min_len + 1);
            endcase
            corrupt[i] = (kinds[i] == kind_bad_fcs);
            if (kinds[i] == kind_runt)
                corrupt[i] = lcg_next() % 2;
            gaps[i] = (i >= 6) ? 2 : 2 + lcg_next() % 8;  // tail runs back to back
            budget_cycles += pre_lens[i] + 1 + lens[i] + gaps[i] + 5;
            if (kinds[i] != kind_broken)
                valid_frames++;
        end
    endtask

    task automatic drive_byte(input logic [7:0] b);
        @(negedge sys_clk);
        phy_data   = b;
        data_valid = 1'b1;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge sys_clk);
            phy_data   = 8'h00;
            data_valid = 1'b0;
        end
    endtask

    task automatic send_frame(input int idx);
        logic [7:0]             fb[$];
        mac_rx_pkg::rx_word_t   w;
        mac_rx_pkg::rx_status_t s;
        logic [31:0]            crc;
        logic [31:0]            fcs;
        logic [31:0]            rnd;
        int                     keep;
        int                     i;
        int                     j;
        int                     bad_pos;
        int                     seen;
        crc = 32'hFFFF_FFFF;
        for (i = 0; i < lens[idx] - 4; i++) begin
            rnd = lcg_next();
            fb.push_back(rnd[7:0]);
            crc = crc_update(crc, rnd[7:0]);
        end
        fcs = ~crc;
        if (corrupt[idx])
            fcs = fcs ^ (32'h1 << (lcg_next() % 32));
        for (i = 0; i < 4; i++)
            fb.push_back(fcs[8*i +: 8]);  // FCS goes out lsb first
        keep = (lens[idx] > max_len) ? max_len : lens[idx];
        if (kinds[idx] != kind_broken) begin
            crc = 32'hFFFF_FFFF;
            for (i = 0; i < keep; i += 4) begin
                w = '0;
                for (j = 0; j < 4 && i + j < keep; j++) begin
                    w.data[31 - 8*j -: 8] = fb[i + j];
                    crc = crc_update(crc, fb[i + j]);
                end
                w.bytes = 3'(j);
                w.last  = (i + 4 >= keep);
                u_checker.expect_word(w);
            end
            s.length   = 16'(keep);
            // a cut frame loses its FCS
            s.crc_err  = (keep < lens[idx]) ? (crc != 32'hDEBB_20E3) : corrupt[idx];
            s.runt     = (keep < min_len);
            s.oversize = (lens[idx] > max_len);
            u_checker.expect_status(s);
        end
        bad_pos = (kinds[idx] == kind_broken) ? lcg_next() % pre_lens[idx] : -1;
        for (i = 0; i < pre_lens[idx]; i++) begin
            rnd = lcg_next();
            if (rnd[7:0] == 8'h55 || rnd[7:0] == 8'hD5)
                rnd[0] = ~rnd[0];
            drive_byte((i == bad_pos) ? rnd[7:0] : 8'h55);
        end
        drive_byte(8'hD5);
        for (i = 0; i < fb.size(); i++)
            drive_byte(fb[i]);
        seen = u_checker.word_cnt + u_checker.done_cnt;
        if (kinds[idx] == kind_broken) begin
            drive_idle(6);  // one edge past where flush and frame_done would be seen
            if (u_checker.word_cnt + u_checker.done_cnt != seen) begin
                $display("burst %0d: broken preamble still produced output", idx);
                tb_errs++;
            end else begin
                $display("burst %0d: broken preamble, no output", idx);
            end
        end
        drive_idle(gaps[idx]);
    endtask

    initial begin
        wait (budget_ready);
        repeat (budget_cycles + 200) @(posedge sys_clk);
        $display("watchdog: run did not finish within %0d cycles", budget_cycles + 200);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int i;
        rst_n      = 1'b0;
        phy_data   = 8'h00;
        data_valid = 1'b0;
        plan_frames();
        budget_ready = 1'b1;
        repeat (5) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;
        drive_idle(3);
        for (i = 0; i < num_frames; i++)
            send_frame(i);
        while (u_checker.pending_status() != 0)
            @(negedge sys_clk);
        drive_idle(2);
        if (u_checker.pending_words() != 0) begin
            $display("%0d expected words never arrived", u_checker.pending_words());
            tb_errs++;
        end
        if (u_checker.done_cnt != valid_frames) begin
            $display("saw %0d frame_done pulses for %0d valid frames", u_checker.done_cnt,
                     valid_frames);
            tb_errs++;
        end
        $display("frames %0d ok, %0d bad, words %0d, errors %0d", u_checker.frames_ok,
                 u_checker.frames_bad, u_checker.word_cnt, u_checker.err_cnt + tb_errs);
        if (u_checker.err_cnt + tb_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: dv/mac_rx_checker.sv
// ------------------------------
// expected word/status queues and
// the comparison against the DUT
// ------------------------------
`timescale 1ns/10ps

module mac_rx_checker (
    input logic                   sys_clk,
    input logic                   rst_n,
    input logic                   word_stb,
    input mac_rx_pkg::rx_word_t   word_out,
    input logic                   frame_done,
    input mac_rx_pkg::rx_status_t status
);
    mac_rx_pkg::rx_word_t   exp_words[$];
    mac_rx_pkg::rx_status_t exp_status[$];
    int word_cnt   = 0;
    int done_cnt   = 0;
    int err_cnt    = 0;
    int frames_ok  = 0;
    int frames_bad = 0;
    int frame_errs = 0;  // mismatches in the frame under way

    task automatic expect_word(input mac_rx_pkg::rx_word_t w);
        exp_words.push_back(w);
    endtask

    task automatic expect_status(input mac_rx_pkg::rx_status_t s);
        exp_status.push_back(s);
    endtask

    function automatic int pending_words();
        return exp_words.size();
    endfunction

    function automatic int pending_status();
        return exp_status.size();
    endfunction

    task automatic value_err(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("Error: %s in frame %0d expected 0x%h got 0x%h", name, done_cnt, exp, got);
        err_cnt++;
        frame_errs++;
    endtask

    task automatic check_word();
        mac_rx_pkg::rx_word_t exp;
        logic [31:0]          mask;
        word_cnt++;
        if (exp_words.size() == 0) begin
            $display("frame %0d: a word arrived that no frame accounts for", done_cnt);
            err_cnt++;
            frame_errs++;
            return;
        end
        exp  = exp_words.pop_front();
        mask = 32'hFFFF_FFFF << (8 * (4 - exp.bytes));  // unused low lanes are don't care
        if ((word_out.data & mask) !== (exp.data & mask))
            value_err("word_out.data", exp.data & mask, word_out.data & mask);
        if (word_out.bytes !== exp.bytes)
            value_err("word_out.bytes", exp.bytes, word_out.bytes);
        if (word_out.last !== exp.last)
            value_err("word_out.last", exp.last, word_out.last);
    endtask

    task automatic check_status();
        mac_rx_pkg::rx_status_t exp;
        if (exp_status.size() == 0) begin
            $display("frame_done pulsed while no frame was expected");
            err_cnt++;
            frames_bad++;
            done_cnt++;
            return;
        end
        exp = exp_status.pop_front();
        if (status.length !== exp.length)
            value_err("status.length", exp.length, status.length);
        if (status.crc_err !== exp.crc_err)
            value_err("status.crc_err", exp.crc_err, status.crc_err);
        if (status.runt !== exp.runt)
            value_err("status.runt", exp.runt, status.runt);
        if (status.oversize !== exp.oversize)
            value_err("status.oversize", exp.oversize, status.oversize);
        if (frame_errs == 0) begin
            frames_ok++;
            $display("frame %0d: length %0d crc_err %0b runt %0b oversize %0b ok", done_cnt,
                     exp.length, exp.crc_err, exp.runt, exp.oversize);
        end else begin
            frames_bad++;
            $display("frame %0d: length %0d, %0d mismatches", done_cnt, exp.length, frame_errs);
        end
        frame_errs = 0;
        done_cnt++;
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge sys_clk) begin
        if (rst_n && word_stb)
            check_word();
        if (rst_n && frame_done)
            check_status();
    end

endmodule

// File: logic/mac_rx.sv
// ------------------------------
// gigabit MAC receive top level
// ------------------------------
`timescale 1ns/10ps

module mac_rx #(
    parameter int min_frame_size = 64,
    parameter int max_frame_size = 1522
) (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  mac_rx_pkg::byte_t      phy_data,
    input  logic                   data_valid,
    output logic                   word_stb,
    output mac_rx_pkg::rx_word_t   word_out,
    output logic                   frame_done,
    output mac_rx_pkg::rx_status_t status
);
    logic                 byte_stb;
    mac_rx_pkg::rx_byte_t rx_byte;
    logic                 frame_end;
    mac_rx_pkg::rx_end_t  end_info;
    logic                 crc_ok;

    mac_rx_ctrl #(
        .max_frame_size (max_frame_size)
    ) u_ctrl (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .phy_data   (phy_data),
        .data_valid (data_valid),
        .byte_stb   (byte_stb),
        .rx_byte    (rx_byte),
        .frame_end  (frame_end),
        .end_info   (end_info)
    );

    rx_crc32 u_crc (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .byte_stb  (byte_stb),
        .rx_byte   (rx_byte),
        .frame_end (frame_end),
        .crc_ok    (crc_ok)
    );

    rx_word_packer u_packer (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .byte_stb  (byte_stb),
        .rx_byte   (rx_byte),
        .frame_end (frame_end),
        .word_stb  (word_stb),
        .word_out  (word_out)
    );

    rx_frame_status #(
        .min_frame_size (min_frame_size),
        .max_frame_size (max_frame_size)
    ) u_status (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .frame_end  (frame_end),
        .end_info   (end_info),
        .crc_ok     (crc_ok),
        .frame_done (frame_done),
        .status     (status)
    );

endmodule

// File: logic/rx_frame_status.sv
// ------------------------------
// per-frame status record
// ------------------------------
`timescale 1ns/10ps

module rx_frame_status #(
    parameter int min_frame_size = 64,
    parameter int max_frame_size = 1522
) (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  logic                   frame_end,
    input  mac_rx_pkg::rx_end_t    end_info,
    input  logic                   crc_ok,
    output logic                   frame_done,
    output mac_rx_pkg::rx_status_t status
);
    localparam mac_rx_pkg::frame_len_t min_len = mac_rx_pkg::frame_len_t'(min_frame_size);

    mac_rx_pkg::frame_len_t len;
    logic                   runt;
    logic                   oversize;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
            len        <= '0;
            runt       <= 1'b0;
            oversize   <= 1'b0;
        end else begin
            frame_done <= frame_end;
            if (frame_end) begin
                len      <= end_info.length;
                runt     <= end_info.length < min_len;
                oversize <= end_info.truncated;
            end
        end
    end

    // crc_ok settles in the same edge as frame_done
    always_comb begin
        status.length   = len;
        status.crc_err  = !crc_ok;
        status.runt     = runt;
        status.oversize = oversize;
    end

endmodule

// File: logic/rx_word_packer.sv
// ------------------------------
// frame bytes to 32-bit words
// ------------------------------
`timescale 1ns/10ps

module rx_word_packer (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 byte_stb,
    input  mac_rx_pkg::rx_byte_t rx_byte,
    input  logic                 frame_end,
    output logic                 word_stb,
    output mac_rx_pkg::rx_word_t word_out
);
    mac_rx_pkg::word_t acc;
    logic [2:0]        fill;       // bytes held in acc
    logic              start_word;
    logic              push_full;
    logic              flush;

    assign start_word = rx_byte.first || fill == 3'd0 || fill == 3'd4;
    // a full word leaves only once a later byte shows it is not the last
    assign push_full  = byte_stb && !rx_byte.first && fill == 3'd4;
    assign flush      = frame_end && fill != 3'd0;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            fill     <= 3'd0;
            word_stb <= 1'b0;
        end else begin
            word_stb <= push_full || flush;
            if (flush) begin
                fill <= 3'd0;
            end else if (byte_stb) begin
                fill <= start_word ? 3'd1 : fill + 3'd1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (byte_stb) begin
            if (start_word) begin
                acc <= {rx_byte.data, 24'h0};  // first byte in the msb
            end else begin
                case (fill)
                    3'd1:    acc[23:16] <= rx_byte.data;
                    3'd2:    acc[15:8]  <= rx_byte.data;
                    default: acc[7:0]   <= rx_byte.data;
                endcase
            end
        end
        if (push_full || flush) begin
            word_out.data  <= acc;
            word_out.bytes <= fill;
            word_out.last  <= flush;
        end
    end

    a_bytes_nonzero: assert property (@(posedge sys_clk) disable iff (!rst_n)
        word_stb |-> word_out.bytes != 3'd0);

endmodule

// File: logic/rx_crc32.sv
// ------------------------------
// byte-wise CRC-32 and residue check
// ------------------------------
`timescale 1ns/10ps

module rx_crc32 (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 byte_stb,
    input  mac_rx_pkg::rx_byte_t rx_byte,
    input  logic                 frame_end,
    output logic                 crc_ok
);
    mac_rx_pkg::crc_t crc;
    mac_rx_pkg::crc_t crc_base;

    // lsb first, one bit per step
    function automatic mac_rx_pkg::crc_t crc_byte(
        input mac_rx_pkg::crc_t  crc_in,
        input mac_rx_pkg::byte_t data
    );
        mac_rx_pkg::crc_t c;
        int               i;
        c = crc_in ^ {24'h0, data};
        for (i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ mac_rx_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_base = rx_byte.first ? mac_rx_pkg::CRC_INIT : crc;  // restart per frame

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            crc    <= mac_rx_pkg::CRC_INIT;
            crc_ok <= 1'b0;
        end else begin
            if (byte_stb) begin
                crc <= crc_byte(crc_base, rx_byte.data);
            end
            // FCS already folded in by now
            if (frame_end) begin
                crc_ok <= (crc == mac_rx_pkg::CRC_RESIDUE);
            end
        end
    end

endmodule

// File: logic/mac_rx_ctrl.sv
// ------------------------------
// input registers, preamble/SFD FSM,
// byte count and frame size limit
// ------------------------------
`timescale 1ns/10ps

module mac_rx_ctrl #(
    parameter int max_frame_size = 1522
) (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  mac_rx_pkg::byte_t    phy_data,
    input  logic                 data_valid,
    output logic                 byte_stb,
    output mac_rx_pkg::rx_byte_t rx_byte,
    output logic                 frame_end,
    output mac_rx_pkg::rx_end_t  end_info
);
    typedef enum logic [1:0] {IDLE, PREAMBLE, DATA, DISCARD} state_t;

    localparam mac_rx_pkg::frame_len_t max_len = mac_rx_pkg::frame_len_t'(max_frame_size);

    state_t                 state;
    mac_rx_pkg::byte_t      s1_data;
    mac_rx_pkg::byte_t      s2_data;
    logic                   s1_valid;
    logic                   s2_valid;
    mac_rx_pkg::frame_len_t byte_cnt;
    logic                   truncated;
    logic                   frame_exit;

    // two register stages on the PHY side
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_data  <= '0;
            s1_valid <= 1'b0;
            s2_data  <= '0;
            s2_valid <= 1'b0;
        end else begin
            s1_data  <= phy_data;
            s1_valid <= data_valid;
            s2_data  <= s1_data;
            s2_valid <= s1_valid;
        end
    end

    assign frame_exit = (state == DATA || state == DISCARD) && !s2_valid;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            byte_cnt  <= '0;
            truncated <= 1'b0;
            byte_stb  <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            byte_stb  <= 1'b0;
            frame_end <= 1'b0;
            case (state)
                IDLE: begin
                    if (s2_valid) begin
                        // junk start, wait for the burst to end
                        state <= (s2_data == mac_rx_pkg::PREAMBLE_BYTE) ? PREAMBLE : DISCARD;
                    end
                end
                PREAMBLE: begin
                    if (!s2_valid) begin
                        state <= IDLE;
                    end else if (s2_data == mac_rx_pkg::SFD_BYTE) begin
                        state     <= DATA;
                        byte_cnt  <= '0;
                        truncated <= 1'b0;
                    end else if (s2_data != mac_rx_pkg::PREAMBLE_BYTE) begin
                        state <= DISCARD;  // broken preamble
                    end
                end
                DATA: begin
                    if (!s2_valid) begin
                        state     <= IDLE;
                        frame_end <= (byte_cnt != '0);  // empty frame is dropped
                    end else if (byte_cnt == max_len) begin
                        state     <= DISCARD;
                        truncated <= 1'b1;
                    end else begin
                        byte_stb <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: begin
                    if (!s2_valid) begin
                        state     <= IDLE;
                        frame_end <= truncated;  // only a cut frame reports
                        truncated <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == DATA && s2_valid) begin
            rx_byte.data  <= s2_data;
            rx_byte.first <= (byte_cnt == '0);
        end
        if (frame_exit) begin
            end_info.length    <= byte_cnt;
            end_info.truncated <= truncated;
        end
    end

    a_stb_in_data: assert property (@(posedge sys_clk) disable iff (!rst_n)
        byte_stb |-> state == DATA);

    a_end_single: assert property (@(posedge sys_clk) disable iff (!rst_n)
        frame_end |=> !frame_end);

endmodule

// File: logic/mac_rx_pkg.sv
// ------------------------------
// shared types, CRC constants and
// the structs between the rx blocks
// ------------------------------
package mac_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] frame_len_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] crc_t;

    // reflected 802.3 polynomial
    localparam crc_t  CRC_POLY    = 32'hEDB8_8320;
    localparam crc_t  CRC_INIT    = 32'hFFFF_FFFF;
    localparam crc_t  CRC_RESIDUE = 32'hDEBB_20E3;  // register value after a good FCS

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    typedef struct packed {
        byte_t data;
        logic  first;       // first byte after SFD
    } rx_byte_t;

    typedef struct packed {
        frame_len_t length;
        logic       truncated;
    } rx_end_t;

    // bytes fill from the msb down
    typedef struct packed {
        word_t      data;
        logic [2:0] bytes;  // 1..4
        logic       last;
    } rx_word_t;

    typedef struct packed {
        frame_len_t length;
        logic       crc_err;
        logic       runt;
        logic       oversize;
    } rx_status_t;

endpackage
